/* tprod_pkg.sv */
//////////////////////////////
// Shared sizes and FSM encodings for the running-product unit
// Default data format is signed Q16.16 in a 32-bit word
//////////////////////////////
`default_nettype none

package tprod_pkg;

  //////////////////////////////
  // Default sizes
  //////////////////////////////

  // Word width of the whole data path
  localparam int DATA_WIDTH_DEF = 32;
  // Fraction bits of the fixed-point format
  localparam int FRAC_BITS_DEF = 16;
  // FIFO depth, power of two only
  localparam int FIFO_DEPTH_DEF = 4;
  // Run-length port width
  localparam int LEN_WIDTH = 16;

  //////////////////////////////
  // FSM encodings
  //////////////////////////////

  // Product-chain controller
  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_pop,
    ctrl_multiply,
    ctrl_offer,
    ctrl_release
  } ctrl_state_t;

  // Sequential multiplier
  typedef enum logic {
    mul_idle,
    mul_run
  } mul_state_t;

endpackage

`default_nettype wire

/* fifo_if.sv */
//////////////////////////////
// FIFO link, push and pop are one-cycle strobes
// pop_data holds the head word whenever empty is low
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
  parameter int DATA_WIDTH = tprod_pkg::DATA_WIDTH_DEF
);

  // Write side
  logic                  push;
  logic [DATA_WIDTH-1:0] push_data;
  logic                  full;

  // Read side, fall-through head word
  logic                  pop;
  logic [DATA_WIDTH-1:0] pop_data;
  logic                  empty;

  // Producer
  modport writer (
    output push,
    output push_data,
    input  full
  );

  // Buffer itself
  modport fifo (
    input  push,
    input  push_data,
    output full,
    input  pop,
    output pop_data,
    output empty
  );

  // Consumer
  modport reader (
    output pop,
    input  pop_data,
    input  empty
  );

endinterface

`default_nettype wire

/* elem_loader.sv */
//////////////////////////////
// Four-phase req/ack sink, one FIFO push per handshake
// in_data must be stable while in_req is high
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_loader #(
  parameter int DATA_WIDTH = tprod_pkg::DATA_WIDTH_DEF
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  in_req,
  output logic                 in_ack,
  input  wire [DATA_WIDTH-1:0] in_data,
  fifo_if.writer               wr
);

  //////////////////////////////
  // Push strobe
  //////////////////////////////

  // New request, not yet acknowledged, and room in the buffer
  // Push lands on the same edge that raises in_ack
  assign wr.push      = in_req && !in_ack && !wr.full;
  assign wr.push_data = in_data;

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////

  // in_ack is the whole state
  // Low: waiting for a request and a free slot
  // High: waiting for the source to drop in_req
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_ack <= 1'b0;
    end else if (!in_ack) begin
      // Word stored, acknowledge it
      if (wr.push) begin
        in_ack <= 1'b1;
      end
    end else begin
      // Held request keeps ack high, so no second push
      if (!in_req) begin
        in_ack <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* elem_fifo.sv */
//////////////////////////////
// Synchronous FIFO, first-word fall-through on pop_data
// DEPTH must be a power of two, 2 or more
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module elem_fifo #(
  parameter int DATA_WIDTH = tprod_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = tprod_pkg::FIFO_DEPTH_DEF
) (
  input wire   CLK,
  input wire   RST,
  fifo_if.fifo q
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage
  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Pointers wrap naturally at DEPTH
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy, 0 to DEPTH
  logic [CNT_W-1:0] count;

  // Qualified strobes
  logic do_push;
  logic do_pop;

  //////////////////////////////
  // Status and head word
  //////////////////////////////

  assign do_push = q.push && !q.full;
  assign do_pop  = q.pop && !q.empty;

  assign q.full     = (count == CNT_W'(DEPTH));
  assign q.empty    = (count == '0);
  assign q.pop_data = mem[rd_ptr];

  //////////////////////////////
  // Storage write
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

  //////////////////////////////
  // Pointers and count
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      // Push and pop together leave the count as is
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* fixed_mul_seq.sv */
//////////////////////////////
// Signed fixed-point shift-add multiplier, one bit per cycle
// Truncates toward zero, wraps on overflow, ready DATA_WIDTH+1 after start
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fixed_mul_seq #(
  parameter int DATA_WIDTH = tprod_pkg::DATA_WIDTH_DEF,
  parameter int FRAC_BITS  = tprod_pkg::FRAC_BITS_DEF
) (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   start,
  input  wire  [DATA_WIDTH-1:0] a,
  input  wire  [DATA_WIDTH-1:0] b,
  output logic                  ready,
  output logic [DATA_WIDTH-1:0] product
);

  localparam int CNT_W = $clog2(DATA_WIDTH);

  tprod_pkg::mul_state_t state;
  logic [CNT_W-1:0]        bit_cnt;

  // Shift-add datapath
  logic [2*DATA_WIDTH-1:0] mcand;
  logic [DATA_WIDTH-1:0]   mplier;
  logic [2*DATA_WIDTH-1:0] acc;
  // Sign of the result
  logic                    neg;

  logic [DATA_WIDTH-1:0]   mag_a;
  logic [DATA_WIDTH-1:0]   mag_b;
  logic [DATA_WIDTH-1:0]   scaled;

  // Magnitudes, most negative value maps to 2**(DATA_WIDTH-1)
  assign mag_a = a[DATA_WIDTH-1] ? (~a + 1'b1) : a;
  assign mag_b = b[DATA_WIDTH-1] ? (~b + 1'b1) : b;

  // Drop fraction bits of the magnitude, then restore the sign
  assign scaled  = acc[FRAC_BITS +: DATA_WIDTH];
  assign product = neg ? (~scaled + 1'b1) : scaled;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= tprod_pkg::mul_idle;
      bit_cnt <= '0;
      ready   <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        tprod_pkg::mul_idle: begin
          if (start) begin
            bit_cnt <= CNT_W'(DATA_WIDTH - 1);
            state   <= tprod_pkg::mul_run;
          end
        end
        tprod_pkg::mul_run: begin
          bit_cnt <= bit_cnt - CNT_W'(1);
          // Last partial sum lands with ready
          if (bit_cnt == '0) begin
            ready <= 1'b1;
            state <= tprod_pkg::mul_idle;
          end
        end
        default: begin
          state <= tprod_pkg::mul_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == tprod_pkg::mul_idle) begin
      // Start while running never reaches here
      if (start) begin
        mcand  <= {{DATA_WIDTH{1'b0}}, mag_a};
        mplier <= mag_b;
        acc    <= '0;
        neg    <= a[DATA_WIDTH-1] ^ b[DATA_WIDTH-1];
      end
    end else begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

endmodule

`default_nettype wire

/* prod_chain_ctrl.sv */
//////////////////////////////
// Running-product consumer, starts each run from 1.0
// Zero length is ignored, start is taken only while idle
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module prod_chain_ctrl #(
  parameter int DATA_WIDTH = tprod_pkg::DATA_WIDTH_DEF,
  parameter int FRAC_BITS  = tprod_pkg::FRAC_BITS_DEF
) (
  input  wire                              CLK,
  input  wire                              RST,
  input  wire                              start,
  input  wire  [tprod_pkg::LEN_WIDTH-1:0]  length,
  output logic                             busy,
  fifo_if.reader                           rd,
  output logic                             out_req,
  input  wire                              out_ack,
  output logic [DATA_WIDTH-1:0]            out_data,
  output logic                             out_last
);

  localparam int LW = tprod_pkg::LEN_WIDTH;
  // 1.0 in the fixed-point format
  localparam logic [DATA_WIDTH-1:0] ONE_FIX = {{(DATA_WIDTH-1){1'b0}}, 1'b1} << FRAC_BITS;

  tprod_pkg::ctrl_state_t state;

  // Run bookkeeping
  logic [LW-1:0]         len_q;
  logic [LW-1:0]         elem_cnt;
  logic                  accept;
  // Running product
  logic [DATA_WIDTH-1:0] acc;

  // Multiplier link
  logic                  mul_start;
  logic                  mul_ready;
  logic [DATA_WIDTH-1:0] mul_product;

  //////////////////////////////
  // Strobes and outputs
  //////////////////////////////

  assign accept = (state == tprod_pkg::ctrl_idle) && start && (length != '0);
  assign busy   = (state != tprod_pkg::ctrl_idle);

  // Pop and multiply on the same cycle, head word goes straight in
  assign mul_start = (state == tprod_pkg::ctrl_pop) && !rd.empty;
  assign rd.pop    = mul_start;

  // Latest partial product
  assign out_data = acc;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= tprod_pkg::ctrl_idle;
      elem_cnt <= '0;
      out_req  <= 1'b0;
      out_last <= 1'b0;
    end else begin
      case (state)
        tprod_pkg::ctrl_idle: begin
          if (accept) begin
            elem_cnt <= '0;
            state    <= tprod_pkg::ctrl_pop;
          end
        end
        tprod_pkg::ctrl_pop: begin
          // Wait for an element
          if (!rd.empty) begin
            state <= tprod_pkg::ctrl_multiply;
          end
        end
        tprod_pkg::ctrl_multiply: begin
          if (mul_ready) begin
            out_req  <= 1'b1;
            out_last <= (elem_cnt == len_q - LW'(1));
            state    <= tprod_pkg::ctrl_offer;
          end
        end
        tprod_pkg::ctrl_offer: begin
          // Data held until the sink takes it
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= tprod_pkg::ctrl_release;
          end
        end
        tprod_pkg::ctrl_release: begin
          // Four-phase close before the next element
          if (!out_ack) begin
            if (out_last) begin
              out_last <= 1'b0;
              state    <= tprod_pkg::ctrl_idle;
            end else begin
              elem_cnt <= elem_cnt + LW'(1);
              state    <= tprod_pkg::ctrl_pop;
            end
          end
        end
        default: begin
          state <= tprod_pkg::ctrl_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // Run length and accumulator
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      len_q <= length;
      acc   <= ONE_FIX;
    end else if ((state == tprod_pkg::ctrl_multiply) && mul_ready) begin
      acc <= mul_product;
    end
  end

  // Element times running product
  fixed_mul_seq #(
    .DATA_WIDTH (DATA_WIDTH),
    .FRAC_BITS  (FRAC_BITS)
  ) mul_inst (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .a       (acc),
    .b       (rd.pop_data),
    .ready   (mul_ready),
    .product (mul_product)
  );

endmodule

`default_nettype wire

/* tensor_product_top.sv */
//////////////////////////////
// Streaming running product, four-phase req/ack on both sides
// busy falls after the final output handshake closes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tensor_product_top #(
  parameter int DATA_WIDTH = tprod_pkg::DATA_WIDTH_DEF,
  parameter int FRAC_BITS  = tprod_pkg::FRAC_BITS_DEF,
  parameter int FIFO_DEPTH = tprod_pkg::FIFO_DEPTH_DEF
) (
  input  wire                              CLK,
  input  wire                              RST,
  // Run control
  input  wire                              start,
  input  wire  [tprod_pkg::LEN_WIDTH-1:0]  length,
  output logic                             busy,
  // Element input port
  input  wire                              in_req,
  output logic                             in_ack,
  input  wire  [DATA_WIDTH-1:0]            in_data,
  // Partial product output port
  output logic                             out_req,
  input  wire                              out_ack,
  output logic [DATA_WIDTH-1:0]            out_data,
  output logic                             out_last
);

  // Loader to controller buffer link
  fifo_if #(.DATA_WIDTH(DATA_WIDTH)) fifo_bus ();

  // Producer
  elem_loader #(
    .DATA_WIDTH (DATA_WIDTH)
  ) loader_inst (
    .CLK     (CLK),
    .RST     (RST),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_data (in_data),
    .wr      (fifo_bus.writer)
  );

  // Buffer
  elem_fifo #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEPTH      (FIFO_DEPTH)
  ) fifo_inst (
    .CLK (CLK),
    .RST (RST),
    .q   (fifo_bus.fifo)
  );

  // Consumer
  prod_chain_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .FRAC_BITS  (FRAC_BITS)
  ) ctrl_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .length   (length),
    .busy     (busy),
    .rd       (fifo_bus.reader),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .out_last (out_last)
  );

endmodule

`default_nettype wire

/* tb_tensor_product.sv */
//////////////////////////////
// Table-driven testbench for the running-product unit
// Q16.16 model with 64-bit products, fixed seed for all random delays
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_product;

  localparam int DW          = 32;
  localparam int FB          = 16;
  localparam int DEPTH       = 4;
  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 10;
  localparam int SEED        = 66;
  // Cycle budget for any single wait
  localparam int WAIT_LIMIT  = 3000;
  // Normal ack takes one cycle, a full FIFO takes far longer
  localparam int HOLDOFF_MIN = 20;
  localparam int NUM_RUNS    = 5;
  localparam int MAX_ELEMS   = 8;

  // 1.0 in Q16.16
  localparam logic [DW-1:0] ONE_FIX = 32'h0001_0000;

  // Selectors for the wait helper
  localparam int SIG_IN_ACK  = 0;
  localparam int SIG_OUT_REQ = 1;
  localparam int SIG_BUSY    = 2;

  logic                            CLK;
  logic                            RST;
  logic                            start;
  logic [tprod_pkg::LEN_WIDTH-1:0] length;
  logic                            busy;
  logic                            in_req;
  logic                            in_ack;
  logic [DW-1:0]                   in_data;
  logic                            out_req;
  logic                            out_ack;
  logic [DW-1:0]                   out_data;
  logic                            out_last;

  int error_count;
  int max_ack_wait;
  int settle_wait;

  //////////////////////////////
  // Run table
  //////////////////////////////

  // Length, slow output sink, second start while busy
  int run_len     [NUM_RUNS] = '{3, 5, 8, 1, 8};
  bit run_slow    [NUM_RUNS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
  bit run_restart [NUM_RUNS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0};

  // Elements in Q16.16, unused slots zero
  logic [DW-1:0] run_elem [NUM_RUNS][MAX_ELEMS] = '{
    '{32'h0002_0000, 32'hFFFE_8000, 32'h0000_4000, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{32'h0001_8000, 32'hFFFF_0000, 32'h0000_AAAB, 32'hFFFD_4000, 32'h0000_0003,
      32'h0, 32'h0, 32'h0},
    '{32'h0001_4000, 32'hFFFF_8000, 32'h0003_0000, 32'h0001_1111, 32'hFFFE_F000,
      32'h0000_7FFF, 32'hFFFE_0000, 32'h0001_999A},
    '{32'hFFFF_AAAB, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{32'h7FFF_0000, 32'h0010_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0002_0000,
      32'hFFFF_4000, 32'h0000_0100, 32'h0001_0000}
  };

  tensor_product_top #(
    .DATA_WIDTH (DW),
    .FRAC_BITS  (FB),
    .FIFO_DEPTH (DEPTH)
  ) tensor_product_top_inst (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .length   (length),
    .busy     (busy),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_data  (in_data),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .out_last (out_last)
  );

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Magnitudes multiplied in 64 bits, fraction dropped, sign put back
  function automatic logic [DW-1:0] fix_mul(input logic [DW-1:0] x, input logic [DW-1:0] y);
    logic [63:0]   mag_x;
    logic [63:0]   mag_y;
    logic [63:0]   prod_wide;
    logic [DW-1:0] kept;
    mag_x     = {32'd0, (x[DW-1] ? (32'd0 - x) : x)};
    mag_y     = {32'd0, (y[DW-1] ? (32'd0 - y) : y)};
    prod_wide = mag_x * mag_y;
    kept      = prod_wide[FB +: DW];
    return (x[DW-1] ^ y[DW-1]) ? (32'd0 - kept) : kept;
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SIG_IN_ACK:  return in_ack;
      SIG_OUT_REQ: return out_req;
      default:     return busy;
    endcase
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s mismatch, expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  // Sampled on falling edges, returns the number of cycles waited
  task automatic wait_signal(input int sel, input logic level, input string what,
                             output int waited);
    waited = 0;
    while (probe(sel) !== level) begin
      if (waited >= WAIT_LIMIT) begin
        $display("Timeout: waited %0d cycles for %s to become %0b", WAIT_LIMIT, what, level);
        abort_run();
      end
      @(negedge CLK);
      waited++;
    end
  endtask

  //////////////////////////////
  // Element source
  //////////////////////////////

  task automatic feed_elements(input int run);
    int gap;
    int waited;
    for (int i = 0; i < run_len[run]; i++) begin
      gap = $urandom % 4;
      repeat (gap) @(negedge CLK);
      in_data = run_elem[run][i];
      in_req  = 1'b1;
      @(negedge CLK);
      wait_signal(SIG_IN_ACK, 1'b1, "in_ack", waited);
      // Longest hold-off seen in this run
      if (waited > max_ack_wait) begin
        max_ack_wait = waited;
      end
      in_req = 1'b0;
      @(negedge CLK);
      wait_signal(SIG_IN_ACK, 1'b0, "in_ack release", waited);
    end
  endtask

  //////////////////////////////
  // Product sink and checker
  //////////////////////////////

  task automatic collect_products(input int run);
    logic [DW-1:0] expected;
    int            stall;
    int            waited;
    expected = ONE_FIX;
    for (int k = 0; k < run_len[run]; k++) begin
      wait_signal(SIG_OUT_REQ, 1'b1, "out_req", waited);
      expected = fix_mul(expected, run_elem[run][k]);
      check_value("out_data", 64'(out_data), 64'(expected));
      check_value("out_last", 64'(out_last), 64'(k == run_len[run] - 1));
      // Slow sink forces the FIFO to fill
      stall = run_slow[run] ? (40 + $urandom % 60) : ($urandom % 3);
      repeat (stall) @(negedge CLK);
      // Offer must hold through the stall
      check_value("out_req held", 64'(out_req), 64'(1));
      check_value("out_data held", 64'(out_data), 64'(expected));
      out_ack = 1'b1;
      @(negedge CLK);
      wait_signal(SIG_OUT_REQ, 1'b0, "out_req release", waited);
      out_ack = 1'b0;
      @(negedge CLK);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    error_count  = 0;
    max_ack_wait = 0;
    RST     = 1'b1;
    start   = 1'b0;
    length  = '0;
    in_req  = 1'b0;
    in_data = '0;
    out_ack = 1'b0;
    repeat (RST_CYCLES) @(negedge CLK);
    RST = 1'b0;

    // Idle outputs out of reset
    check_value("in_ack after reset", 64'(in_ack), 64'(0));
    check_value("out_req after reset", 64'(out_req), 64'(0));
    check_value("out_last after reset", 64'(out_last), 64'(0));
    check_value("busy after reset", 64'(busy), 64'(0));
    @(negedge CLK);

    for (int r = 0; r < NUM_RUNS; r++) begin
      max_ack_wait = 0;
      start  = 1'b1;
      length = tprod_pkg::LEN_WIDTH'(run_len[r]);
      @(negedge CLK);
      start = 1'b0;
      check_value("busy after start", 64'(busy), 64'(1));
      // Second start with another length, must be ignored
      if (run_restart[r]) begin
        start  = 1'b1;
        length = tprod_pkg::LEN_WIDTH'(run_len[r] + 3);
        @(negedge CLK);
        start = 1'b0;
      end
      fork
        feed_elements(r);
        collect_products(r);
      join
      wait_signal(SIG_BUSY, 1'b0, "busy end of run", settle_wait);
      // busy drops on the edge that sees the last out_ack fall
      check_value("busy fall delay", 64'(settle_wait), 64'(0));
      // No extra product after the last one
      repeat (3) begin
        @(negedge CLK);
        check_value("out_req after run", 64'(out_req), 64'(0));
        check_value("busy after run", 64'(busy), 64'(0));
      end
      if (run_slow[r]) begin
        check_value("in_ack hold-off with full FIFO", 64'(max_ack_wait > HOLDOFF_MIN),
                    64'(1));
      end
    end

    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* tensor_product.f */
tprod_pkg.sv
fifo_if.sv
elem_loader.sv
elem_fifo.sv
fixed_mul_seq.sv
prod_chain_ctrl.sv
tensor_product_top.sv
tb_tensor_product.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_tensor_product -f tensor_product.f \
  -o tb_tensor_product_sim && ./obj_dir/tb_tensor_product_sim || exit 1
